// File: src/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // Controller states, one transaction per request
    typedef enum logic [3:0] {
        idle,
        start,
        send_byte,
        check_ack,
        restart,
        receive_byte,
        send_nack,
        send_stop
    } i2c_state_t;

    // Byte of the frame in flight
    typedef enum logic [1:0] {
        address_write,
        register,
        write_data,
        address_read
    } frame_step_t;

    // Quarters of one SCL period
    typedef enum logic [1:0] {
        setup,
        rise,
        high,
        fall
    } bit_phase_t;

    typedef struct packed {
        logic       read_write;
        logic [6:0] device_address;
        logic [7:0] register_address;
        logic [7:0] write_data;
    } i2c_request_t;

    // Sensed levels, or drive-low requests
    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_lines_t;

    typedef logic [15:0] divider_t;

endpackage

`default_nettype wire

// File: src/bit_clock_timer.sv
`timescale 1ns/1ps
`default_nettype none

module bit_clock_timer #(
    parameter logic [15:0] STRETCH_LIMIT = 16'd255
) (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire i2c_pkg::divider_t divider,
    input  wire                    stretch_restart,
    output logic                   tick,
    output logic                   stretch_expired
);

    i2c_pkg::divider_t divider_count;
    logic [15:0]       stretch_count;

    // Also catches a divider lowered below the running count
    assign tick = (divider_count >= divider);

    assign stretch_expired = (stretch_count == 16'd0);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            divider_count <= '0;
        end
        else if (tick) begin
            divider_count <= '0;
        end
        else begin
            divider_count <= divider_count + 16'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stretch timeout, counts ticks while SCL is held in the rise quarter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n || stretch_restart) begin
            stretch_count <= STRETCH_LIMIT;
        end
        else if (tick && !stretch_expired) begin
            stretch_count <= stretch_count - 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: src/frame_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_shifter (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        capture,
    input  wire i2c_pkg::i2c_request_t request,
    input  wire                        load,
    input  wire i2c_pkg::frame_step_t  load_step,
    input  wire                        shift_out,
    input  wire                        sample,
    input  wire                        rx_bit,
    output logic                       tx_bit,
    output logic                       is_read,
    output logic [7:0]                 read_data
);

    i2c_pkg::i2c_request_t saved_request;
    logic [7:0]            tx_byte;

    assign tx_bit  = tx_byte[7];
    assign is_read = saved_request.read_write;

    // Request is held for the whole transaction
    always_ff @(posedge clock) begin
        if (capture) begin
            saved_request <= request;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outgoing byte, MSB first
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load) begin
            case (load_step)
                i2c_pkg::address_write: begin
                    tx_byte <= {saved_request.device_address, 1'b0};
                end
                i2c_pkg::address_read: begin
                    tx_byte <= {saved_request.device_address, 1'b1};
                end
                i2c_pkg::register: begin
                    tx_byte <= saved_request.register_address;
                end
                default: begin
                    tx_byte <= saved_request.write_data;
                end
            endcase
        end
        else if (shift_out) begin
            tx_byte <= {tx_byte[6:0], tx_byte[7]};
        end
    end

    // First bit in ends up as MSB
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            read_data <= 8'h00;
        end
        else if (sample) begin
            read_data <= {read_data[6:0], rx_bit};
        end
    end

endmodule

`default_nettype wire

// File: src/transfer_controller.sv
`timescale 1ns/1ps
`default_nettype none

module transfer_controller (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       enable,
    input  wire                       tick,
    input  wire                       stretch_expired,
    input  wire i2c_pkg::i2c_lines_t  bus_in,
    input  wire                       tx_bit,
    input  wire                       is_read,
    output logic                      capture,
    output logic                      load,
    output i2c_pkg::frame_step_t      load_step,
    output logic                      shift_out,
    output logic                      sample,
    output logic                      stretch_restart,
    output i2c_pkg::i2c_lines_t       bus_drive_low,
    output logic                      busy
);

    i2c_pkg::i2c_state_t  state;
    i2c_pkg::i2c_state_t  next_state;
    i2c_pkg::bit_phase_t  phase;
    i2c_pkg::bit_phase_t  next_phase;
    i2c_pkg::frame_step_t step;
    i2c_pkg::frame_step_t next_step;
    logic [2:0]           bit_count;
    logic [2:0]           next_bit_count;
    logic                 ack_seen;
    logic                 next_ack_seen;
    logic                 scl_low_phase;
    logic                 last_bit;

    assign scl_low_phase   = (phase == i2c_pkg::setup) || (phase == i2c_pkg::fall);
    assign last_bit        = (bit_count == 3'd0);
    assign stretch_restart = (phase != i2c_pkg::rise);

    ////////////////////////////////////////////////////////////////////////////
    // Open-drain drive, SDA only moves while SCL is held low
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        bus_drive_low = '0;
        case (state)
            i2c_pkg::start: begin
                bus_drive_low.scl = (phase == i2c_pkg::fall);
                bus_drive_low.sda = (phase == i2c_pkg::high) || (phase == i2c_pkg::fall);
            end
            i2c_pkg::restart: begin
                bus_drive_low.scl = scl_low_phase;
                bus_drive_low.sda = (phase == i2c_pkg::high) || (phase == i2c_pkg::fall);
            end
            i2c_pkg::send_byte: begin
                bus_drive_low.scl = scl_low_phase;
                bus_drive_low.sda = !tx_bit;
            end
            i2c_pkg::check_ack,
            i2c_pkg::receive_byte,
            i2c_pkg::send_nack: begin
                bus_drive_low.scl = scl_low_phase;
            end
            i2c_pkg::send_stop: begin
                // SDA released last, with SCL high
                bus_drive_low.scl = (phase == i2c_pkg::setup);
                bus_drive_low.sda = (phase != i2c_pkg::fall);
            end
            default: begin
                bus_drive_low = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state     = state;
        next_phase     = phase;
        next_step      = step;
        next_bit_count = bit_count;
        next_ack_seen  = ack_seen;
        capture        = 1'b0;
        load           = 1'b0;
        shift_out      = 1'b0;
        sample         = 1'b0;

        if (state == i2c_pkg::idle) begin
            next_phase = i2c_pkg::setup;
            if (enable) begin
                capture    = 1'b1;
                next_state = i2c_pkg::start;
                next_step  = i2c_pkg::address_write;
            end
        end
        else if (tick) begin
            case (phase)
                i2c_pkg::setup: begin
                    next_phase = i2c_pkg::rise;
                end
                i2c_pkg::rise: begin
                    // Target may hold SCL low
                    if (bus_in.scl) begin
                        next_phase = i2c_pkg::high;
                    end
                    else if (stretch_expired) begin
                        next_state = i2c_pkg::idle;
                        next_phase = i2c_pkg::setup;
                    end
                end
                i2c_pkg::high: begin
                    next_phase = i2c_pkg::fall;
                    if (state == i2c_pkg::check_ack) begin
                        next_ack_seen = !bus_in.sda;
                    end
                    if (state == i2c_pkg::receive_byte) begin
                        sample = 1'b1;
                    end
                end
                default: begin
                    next_phase = i2c_pkg::setup;
                    case (state)
                        i2c_pkg::start,
                        i2c_pkg::restart: begin
                            next_state     = i2c_pkg::send_byte;
                            next_bit_count = 3'd7;
                            load           = 1'b1;
                        end
                        i2c_pkg::send_byte: begin
                            if (last_bit) begin
                                next_state = i2c_pkg::check_ack;
                            end
                            else begin
                                shift_out      = 1'b1;
                                next_bit_count = bit_count - 3'd1;
                            end
                        end
                        i2c_pkg::check_ack: begin
                            if (!ack_seen) begin
                                next_state = i2c_pkg::send_stop;
                            end
                            else begin
                                case (step)
                                    i2c_pkg::address_write: begin
                                        next_step      = i2c_pkg::register;
                                        next_state     = i2c_pkg::send_byte;
                                        next_bit_count = 3'd7;
                                        load           = 1'b1;
                                    end
                                    i2c_pkg::register: begin
                                        if (is_read) begin
                                            next_step  = i2c_pkg::address_read;
                                            next_state = i2c_pkg::restart;
                                        end
                                        else begin
                                            next_step      = i2c_pkg::write_data;
                                            next_state     = i2c_pkg::send_byte;
                                            next_bit_count = 3'd7;
                                            load           = 1'b1;
                                        end
                                    end
                                    i2c_pkg::write_data: begin
                                        next_state = i2c_pkg::send_stop;
                                    end
                                    default: begin
                                        next_state     = i2c_pkg::receive_byte;
                                        next_bit_count = 3'd7;
                                    end
                                endcase
                            end
                        end
                        i2c_pkg::receive_byte: begin
                            if (last_bit) begin
                                next_state = i2c_pkg::send_nack;
                            end
                            else begin
                                next_bit_count = bit_count - 3'd1;
                            end
                        end
                        i2c_pkg::send_nack: begin
                            next_state = i2c_pkg::send_stop;
                        end
                        default: begin
                            next_state = i2c_pkg::idle;
                        end
                    endcase
                end
            endcase
        end

        load_step = next_step;
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= i2c_pkg::idle;
            phase     <= i2c_pkg::setup;
            step      <= i2c_pkg::address_write;
            bit_count <= 3'd0;
            ack_seen  <= 1'b0;
            busy      <= 1'b0;
        end
        else begin
            state     <= next_state;
            phase     <= next_phase;
            step      <= next_step;
            bit_count <= next_bit_count;
            ack_seen  <= next_ack_seen;
            busy      <= (next_state != i2c_pkg::idle);
        end
    end

endmodule

`default_nettype wire

// File: src/i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_master #(
    parameter logic [15:0] STRETCH_LIMIT = 16'd255
) (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire                        enable,
    input  wire i2c_pkg::i2c_request_t request,
    input  wire i2c_pkg::divider_t     divider,
    input  wire i2c_pkg::i2c_lines_t   bus_in,
    output i2c_pkg::i2c_lines_t        bus_drive_low,
    output logic [7:0]                 read_data,
    output logic                       busy
);

    logic                 tick;
    logic                 stretch_restart;
    logic                 stretch_expired;
    logic                 capture;
    logic                 load;
    i2c_pkg::frame_step_t load_step;
    logic                 shift_out;
    logic                 sample;
    logic                 tx_bit;
    logic                 is_read;

    bit_clock_timer #(
        .STRETCH_LIMIT   (STRETCH_LIMIT)
    ) timer (
        .clock           (clock),
        .reset_n         (reset_n),
        .divider         (divider),
        .stretch_restart (stretch_restart),
        .tick            (tick),
        .stretch_expired (stretch_expired)
    );

    frame_shifter shifter (
        .clock     (clock),
        .reset_n   (reset_n),
        .capture   (capture),
        .request   (request),
        .load      (load),
        .load_step (load_step),
        .shift_out (shift_out),
        .sample    (sample),
        .rx_bit    (bus_in.sda),
        .tx_bit    (tx_bit),
        .is_read   (is_read),
        .read_data (read_data)
    );

    transfer_controller controller (
        .clock           (clock),
        .reset_n         (reset_n),
        .enable          (enable),
        .tick            (tick),
        .stretch_expired (stretch_expired),
        .bus_in          (bus_in),
        .tx_bit          (tx_bit),
        .is_read         (is_read),
        .capture         (capture),
        .load            (load),
        .load_step       (load_step),
        .shift_out       (shift_out),
        .sample          (sample),
        .stretch_restart (stretch_restart),
        .bus_drive_low   (bus_drive_low),
        .busy            (busy)
    );

endmodule

`default_nettype wire

// File: tests/i2c_target_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] DEVICE_ADDRESS = 7'h2A
) (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire i2c_pkg::i2c_lines_t bus_in,
    input  wire [7:0]                stretch_cycles,
    output i2c_pkg::i2c_lines_t      bus_drive_low,
    output logic [3:0][7:0]          register_file,
    output logic [7:0]               stop_count
);

    i2c_pkg::i2c_lines_t last_level;
    logic [3:0]          bit_count;
    logic [1:0]          byte_index;
    logic [1:0]          pointer;
    logic [7:0]          rx_byte;
    logic [7:0]          tx_byte;
    logic [7:0]          hold_count;
    logic                listening;
    logic                sending;
    logic                read_request;
    logic                start_seen;
    logic                stop_seen;
    logic                scl_rise;
    logic                scl_fall;

    assign start_seen = last_level.scl && bus_in.scl && last_level.sda && !bus_in.sda;
    assign stop_seen  = last_level.scl && bus_in.scl && !last_level.sda && bus_in.sda;
    assign scl_rise   = !last_level.scl && bus_in.scl;
    assign scl_fall   = last_level.scl && !bus_in.scl;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            last_level    <= '1;
            bus_drive_low <= '0;
            bit_count     <= 4'd0;
            byte_index    <= 2'd0;
            hold_count    <= 8'd0;
            listening     <= 1'b0;
            sending       <= 1'b0;
            read_request  <= 1'b0;
            stop_count    <= 8'd0;
            for (int i = 0; i < 4; i++) begin
                register_file[2'(i)] <= 8'h30 + 8'(i);
            end
        end
        else begin
            last_level <= bus_in;

            // Hold SCL low after each falling edge
            if (scl_fall && stretch_cycles != 8'd0) begin
                hold_count        <= stretch_cycles;
                bus_drive_low.scl <= 1'b1;
            end
            else if (hold_count > 8'd1) begin
                hold_count <= hold_count - 8'd1;
            end
            else begin
                hold_count        <= 8'd0;
                bus_drive_low.scl <= 1'b0;
            end

            if (start_seen) begin
                listening         <= 1'b1;
                sending           <= 1'b0;
                read_request      <= 1'b0;
                bit_count         <= 4'd0;
                byte_index        <= 2'd0;
                bus_drive_low.sda <= 1'b0;
            end
            else if (stop_seen) begin
                stop_count        <= stop_count + 8'd1;
                listening         <= 1'b0;
                sending           <= 1'b0;
                bus_drive_low.sda <= 1'b0;
            end
            else if (scl_rise) begin
                if (bit_count < 4'd8) begin
                    rx_byte <= {rx_byte[6:0], bus_in.sda};
                end
                bit_count <= bit_count + 4'd1;
            end
            else if (scl_fall) begin
                if (bit_count == 4'd8) begin
                    // Acknowledge slot comes next
                    bus_drive_low.sda <= 1'b0;
                    if (listening && !sending) begin
                        case (byte_index)
                            2'd0: begin
                                if (rx_byte[7:1] == DEVICE_ADDRESS) begin
                                    bus_drive_low.sda <= 1'b1;
                                    read_request      <= rx_byte[0];
                                end
                                else begin
                                    listening <= 1'b0;
                                end
                            end
                            2'd1: begin
                                pointer           <= rx_byte[1:0];
                                bus_drive_low.sda <= 1'b1;
                            end
                            default: begin
                                register_file[pointer] <= rx_byte;
                                bus_drive_low.sda      <= 1'b1;
                            end
                        endcase
                    end
                end
                else if (bit_count == 4'd9) begin
                    bit_count         <= 4'd0;
                    byte_index        <= byte_index + 2'd1;
                    bus_drive_low.sda <= 1'b0;
                    if (sending) begin
                        sending   <= 1'b0;
                        listening <= 1'b0;
                    end
                    else if (listening && read_request) begin
                        sending           <= 1'b1;
                        tx_byte           <= register_file[pointer];
                        bus_drive_low.sda <= !register_file[pointer][7];
                    end
                end
                else if (sending && bit_count != 4'd0) begin
                    bus_drive_low.sda <= !tx_byte[3'd7 - bit_count[2:0]];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master;

    localparam int          ROWS          = 10;
    localparam logic [15:0] STRETCH_LIMIT = 16'd16;

    typedef struct packed {
        i2c_pkg::i2c_request_t request;
        logic [7:0]            stretch_cycles;
        logic                  expect_ack;
        logic                  expect_timeout;
        logic [7:0]            expect_read;
    } test_row_t;

    logic                  clock;
    logic                  reset_n;
    logic                  enable;
    i2c_pkg::i2c_request_t request;
    i2c_pkg::divider_t     divider;
    i2c_pkg::i2c_lines_t   dut_drive_low;
    i2c_pkg::i2c_lines_t   target_drive_low;
    i2c_pkg::i2c_lines_t   bus_level;
    logic [7:0]            read_data;
    logic                  busy;
    logic [7:0]            stretch_cycles;
    logic [3:0][7:0]       register_file;
    logic [7:0]            stop_count;

    test_row_t  rows [ROWS];
    logic [7:0] mirror [4];
    logic [7:0] last_read;
    int         error_count;
    int         cycle_count;
    int         cycle_limit;

    // Wired-AND of both open-drain drivers
    assign bus_level = ~(dut_drive_low | target_drive_low);

    always #20 clock = ~clock;

    i2c_master #(
        .STRETCH_LIMIT (STRETCH_LIMIT)
    ) uut (
        .clock         (clock),
        .reset_n       (reset_n),
        .enable        (enable),
        .request       (request),
        .divider       (divider),
        .bus_in        (bus_level),
        .bus_drive_low (dut_drive_low),
        .read_data     (read_data),
        .busy          (busy)
    );

    i2c_target_model target (
        .clock          (clock),
        .reset_n        (reset_n),
        .bus_in         (bus_level),
        .stretch_cycles (stretch_cycles),
        .bus_drive_low  (target_drive_low),
        .register_file  (register_file),
        .stop_count     (stop_count)
    );

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d errors so far", cycle_count, error_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_byte(input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, actual, expected);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One transaction, checked once busy falls
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_row(input test_row_t row);
        logic [7:0] stops_before;
        logic [7:0] expected_stops;
        logic [1:0] index;

        stops_before   = stop_count;
        expected_stops = row.expect_timeout ? 8'd0 : 8'd1;
        @(posedge clock);
        request        <= row.request;
        stretch_cycles <= row.stretch_cycles;
        enable         <= 1'b1;
        @(posedge clock);
        enable <= 1'b0;

        @(negedge clock);
        while (!busy) begin
            @(negedge clock);
        end
        while (busy) begin
            @(negedge clock);
        end

        compare_byte("read_data", read_data, row.expect_read);
        compare_byte("bus_drive_low", {6'b0, dut_drive_low}, 8'h00);
        compare_byte("stop_count increase", stop_count - stops_before, expected_stops);
        for (int i = 0; i < 4; i++) begin
            index = 2'(i);
            compare_byte($sformatf("register_file[%0d]", i), register_file[index],
                         mirror[index]);
        end

        // Target may still hold SCL after an abort
        while (!(bus_level.scl && bus_level.sda)) begin
            @(negedge clock);
        end
    endtask

    initial begin
        logic [1:0] index;

        clock          = 1'b0;
        reset_n        = 1'b0;
        enable         = 1'b0;
        request        = '0;
        divider        = 16'd3;
        stretch_cycles = 8'd0;
        error_count    = 0;
        cycle_count    = 0;
        last_read      = 8'h00;
        void'($urandom(21));

        // read_write, device_address, register_address, write_data,
        // stretch_cycles, expect_ack, expect_timeout, expect_read
        rows[0] = {1'b0, 7'h2A, 8'h05, 8'h00, 8'd0, 1'b1, 1'b0, 8'h00};
        rows[1] = {1'b1, 7'h2A, 8'h05, 8'h00, 8'd0, 1'b1, 1'b0, 8'h00};
        rows[2] = {1'b0, 7'h2A, 8'h0E, 8'h00, 8'd0, 1'b1, 1'b0, 8'h00};
        rows[3] = {1'b1, 7'h2A, 8'h0E, 8'h00, 8'd0, 1'b1, 1'b0, 8'h00};
        rows[4] = {1'b0, 7'h15, 8'h0E, 8'h00, 8'd0, 1'b0, 1'b0, 8'h00};
        rows[5] = {1'b1, 7'h15, 8'h05, 8'h00, 8'd0, 1'b0, 1'b0, 8'h00};
        rows[6] = {1'b0, 7'h2A, 8'h03, 8'h00, 8'd30, 1'b1, 1'b0, 8'h00};
        rows[7] = {1'b1, 7'h2A, 8'h03, 8'h00, 8'd30, 1'b1, 1'b0, 8'h00};
        rows[8] = {1'b0, 7'h2A, 8'h80, 8'h00, 8'd120, 1'b1, 1'b1, 8'h00};
        rows[9] = {1'b1, 7'h2A, 8'h80, 8'h00, 8'd0, 1'b1, 1'b0, 8'h00};

        // Target registers come out of reset as 0x30 plus index
        for (int i = 0; i < 4; i++) begin
            mirror[i] = 8'h30 + 8'(i);
        end

        cycle_limit = ROWS * 40 * 4 * 4;
        for (int n = 0; n < ROWS; n++) begin
            cycle_limit = cycle_limit + int'(rows[n].stretch_cycles);
        end
        cycle_limit = 2 * cycle_limit;

        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        compare_byte("busy", {7'b0, busy}, 8'h00);
        compare_byte("bus_drive_low", {6'b0, dut_drive_low}, 8'h00);
        compare_byte("read_data", read_data, 8'h00);

        for (int n = 0; n < ROWS; n++) begin
            index = rows[n].request.register_address[1:0];
            if (!rows[n].request.read_write) begin
                rows[n].request.write_data = 8'($urandom);
                if (rows[n].expect_ack && !rows[n].expect_timeout) begin
                    mirror[index] = rows[n].request.write_data;
                end
            end
            else if (rows[n].expect_ack && !rows[n].expect_timeout) begin
                last_read = mirror[index];
            end
            // read_data holds its value unless a read completes
            rows[n].expect_read = last_read;
            run_row(rows[n]);
        end

        $display("Checks finished over %0d rows with %0d errors", ROWS, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/i2c_pkg.sv
src/bit_clock_timer.sv
src/frame_shifter.sv
src/transfer_controller.sv
src/i2c_master.sv
tests/i2c_target_model.sv
tests/tb_i2c_master.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -j 0 --top-module tb_i2c_master -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
